/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - alu.sv
      - fetch_unit.sv
      - instr_decoder.sv
      - execute_stage.sv
      - writeback_regfile.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

/* alu.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module alu import rv_pkg::*; (
    input  alu_op_e             op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32 shifts use five bits

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;  // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

/* build.f */
+incdir+.
rv_pkg.sv
alu.sv
fetch_unit.sv
instr_decoder.sv
execute_stage.sv
writeback_regfile.sv
rv_core.sv
tb_rv_core.sv

/* execute_stage.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module execute_stage import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [`RV_XLEN-1:0] id_pc,
    input  logic [4:0]          id_rs1,
    input  logic [4:0]          id_rs2,
    input  logic [4:0]          id_rd,
    input  logic [`RV_XLEN-1:0] id_rs1_data,
    input  logic [`RV_XLEN-1:0] id_rs2_data,
    input  logic [`RV_XLEN-1:0] id_imm,
    input  alu_op_e             id_alu_op,
    input  logic                id_use_imm,
    input  logic                id_reg_write,
    input  branch_op_e          id_branch_op,
    input  logic [4:0]          wb_rd,
    input  logic                wb_reg_write,
    input  logic [`RV_XLEN-1:0] wb_data,
    output logic [4:0]          ex_rd,
    output logic                ex_reg_write,
    output logic [`RV_XLEN-1:0] ex_result,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc
);

    logic [`RV_XLEN-1:0] rs1_fwd;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;

    // ------------------------------------------------------------------------
    // Forwarding, youngest producer first
    // ------------------------------------------------------------------------
    function automatic logic [`RV_XLEN-1:0] fwd(input logic [4:0] rs,
                                                input logic [`RV_XLEN-1:0] reg_val);
        if (ex_reg_write && ex_rd != 5'd0 && ex_rd == rs) begin
            return ex_result;   // EX/MEM
        end else if (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs) begin
            return wb_data;     // MEM/WB
        end
        return reg_val;         // Register file, already write-through
    endfunction

    always_comb begin
        rs1_fwd = fwd(id_rs1, id_rs1_data);
        rs2_fwd = fwd(id_rs2, id_rs2_data);
    end

    assign alu_b = id_use_imm ? id_imm : rs2_fwd;

    alu u_alu (
        .op     (id_alu_op),
        .a      (rs1_fwd),
        .b      (alu_b),
        .result (alu_result)
    );

    // ------------------------------------------------------------------------
    // Branch resolution
    // ------------------------------------------------------------------------
    always_comb begin
        case (id_branch_op)
            BR_BEQ:  redirect = (alu_result == '0);
            BR_BNE:  redirect = (alu_result != '0);
            default: redirect = 1'b0;
        endcase
    end

    assign redirect_pc = id_pc + id_imm;

    // EX/MEM register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_reg_write <= 1'b0;
        end else begin
            ex_reg_write <= id_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd     <= id_rd;
        ex_result <= alu_result;
    end

    // A redirect comes only from a decoded branch, which writes no register
    redirect_from_branch: assert property (@(posedge clk) disable iff (!reset_n)
        redirect |-> (id_branch_op != BR_NONE && !id_reg_write))
        else $error("execute_stage: redirect without branch");

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] instr_addr,
    input  logic [31:0]         instr_data,
    output logic [`RV_XLEN-1:0] if_pc,
    output logic [31:0]         if_instr,
    output logic                if_valid
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;

    assign instr_addr = pc;  // Memory answers within the cycle

    // Taken branch from EX wins over sequential fetch
    assign pc_next = redirect ? redirect_pc : pc + 4;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // ------------------------------------------------------------------------
    // IF/ID register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if_pc    <= pc;
        if_instr <= instr_data;
    end

    // Word fetched alongside a redirect is on the wrong path
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= !redirect;
        end
    end

    // Branch targets computed in EX must keep the PC aligned
    pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        instr_addr[1:0] == 2'b00)
        else $error("fetch_unit: misaligned PC %h", instr_addr);

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module instr_decoder import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [`RV_XLEN-1:0] if_pc,
    input  logic [31:0]         if_instr,
    input  logic                if_valid,
    input  logic                redirect,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic [`RV_XLEN-1:0] id_pc,
    output logic [4:0]          id_rs1,
    output logic [4:0]          id_rs2,
    output logic [4:0]          id_rd,
    output logic [`RV_XLEN-1:0] id_rs1_data,
    output logic [`RV_XLEN-1:0] id_rs2_data,
    output logic [`RV_XLEN-1:0] id_imm,
    output alu_op_e             id_alu_op,
    output logic                id_use_imm,
    output logic                id_reg_write,
    output branch_op_e          id_branch_op
);

    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_sh;
    logic [`RV_XLEN-1:0] imm_b;

    alu_op_e             dec_alu_op;
    logic                dec_use_imm;
    logic [`RV_XLEN-1:0] dec_imm;
    logic                dec_reg_write;
    branch_op_e          dec_branch_op;
    logic                dec_known;
    logic                bubble;

    // ------------------------------------------------------------------------
    // Field and immediate extraction
    // ------------------------------------------------------------------------
    assign opcode   = opcode_e'(if_instr[6:0]);
    assign funct3   = if_instr[14:12];
    assign funct7   = if_instr[31:25];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    assign imm_i  = {{(`RV_XLEN-12){if_instr[31]}}, if_instr[31:20]};
    assign imm_sh = {{(`RV_XLEN-5){1'b0}}, if_instr[24:20]};
    assign imm_b  = {{(`RV_XLEN-13){if_instr[31]}}, if_instr[31], if_instr[7],
                     if_instr[30:25], if_instr[11:8], 1'b0};

    // funct3 map shared by OP and OP-IMM; bit 30 selects SUB only in R form
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic reg_form);
        case (f3)
            3'b000:  return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------------
    always_comb begin
        dec_alu_op    = ALU_ADD;
        dec_use_imm   = 1'b0;
        dec_imm       = imm_i;
        dec_reg_write = 1'b0;
        dec_branch_op = BR_NONE;
        dec_known     = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec_reg_write = 1'b1;
                dec_alu_op    = arith_op(funct3, funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                dec_alu_op    = arith_op(funct3, funct7[5], 1'b0);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    dec_imm = imm_sh;  // Shift amount only
                end
            end
            OPC_BRANCH: begin
                dec_alu_op = ALU_SUB;  // Compare by difference
                dec_imm    = imm_b;
                case (funct3)
                    3'b000:  dec_branch_op = BR_BEQ;
                    3'b001:  dec_branch_op = BR_BNE;
                    default: dec_known = 1'b0;
                endcase
            end
            default: dec_known = 1'b0;
        endcase
    end

    assign bubble = redirect || !if_valid || !dec_known;

    // ------------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_reg_write <= 1'b0;
            id_branch_op <= BR_NONE;
        end else if (bubble) begin
            id_reg_write <= 1'b0;
            id_branch_op <= BR_NONE;
        end else begin
            id_reg_write <= dec_reg_write;
            id_branch_op <= dec_branch_op;
        end
    end

    always_ff @(posedge clk) begin
        id_pc       <= if_pc;
        id_rs1      <= rs1_addr;
        id_rs2      <= rs2_addr;
        id_rd       <= if_instr[11:7];
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= dec_imm;
        id_alu_op   <= dec_alu_op;
        id_use_imm  <= dec_use_imm;
    end

    // Both slots behind a taken branch reach EX as harmless bubbles
    bubble_is_inert: assert property (@(posedge clk) disable iff (!reset_n)
        redirect |=> (!id_reg_write && id_branch_op == BR_NONE)
                     ##1 (!id_reg_write && id_branch_op == BR_NONE))
        else $error("instr_decoder: bubble carries side effects");

endmodule

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data path and address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Writes to this register show up on the result port (x10, a0)
`define RV_RESULT_REG 5'd10

`endif

/* rv_core.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,
    output logic [`RV_XLEN-1:0] instr_addr,
    input  logic [31:0]         instr_data,
    output logic                result_valid,
    output logic [`RV_XLEN-1:0] result_data
);

    // IF/ID
    logic [`RV_XLEN-1:0] if_pc;
    logic [31:0]         if_instr;
    logic                if_valid;

    // Decode read ports
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    // ID/EX
    logic [`RV_XLEN-1:0] id_pc;
    logic [4:0]          id_rs1;
    logic [4:0]          id_rs2;
    logic [4:0]          id_rd;
    logic [`RV_XLEN-1:0] id_rs1_data;
    logic [`RV_XLEN-1:0] id_rs2_data;
    logic [`RV_XLEN-1:0] id_imm;
    alu_op_e             id_alu_op;
    logic                id_use_imm;
    logic                id_reg_write;
    branch_op_e          id_branch_op;

    // EX/MEM and MEM/WB
    logic [4:0]          ex_rd;
    logic                ex_reg_write;
    logic [`RV_XLEN-1:0] ex_result;
    logic [4:0]          wb_rd;
    logic                wb_reg_write;
    logic [`RV_XLEN-1:0] wb_data;

    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .if_pc       (if_pc),
        .if_instr    (if_instr),
        .if_valid    (if_valid)
    );

    instr_decoder u_decode (
        .clk          (clk),
        .reset_n      (reset_n),
        .if_pc        (if_pc),
        .if_instr     (if_instr),
        .if_valid     (if_valid),
        .redirect     (redirect),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_alu_op    (id_alu_op),
        .id_use_imm   (id_use_imm),
        .id_reg_write (id_reg_write),
        .id_branch_op (id_branch_op)
    );

    execute_stage u_execute (
        .clk          (clk),
        .reset_n      (reset_n),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_alu_op    (id_alu_op),
        .id_use_imm   (id_use_imm),
        .id_reg_write (id_reg_write),
        .id_branch_op (id_branch_op),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write),
        .wb_data      (wb_data),
        .ex_rd        (ex_rd),
        .ex_reg_write (ex_reg_write),
        .ex_result    (ex_result),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    writeback_regfile u_writeback (
        .clk          (clk),
        .reset_n      (reset_n),
        .ex_rd        (ex_rd),
        .ex_reg_write (ex_reg_write),
        .ex_result    (ex_result),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // R-type ALU
        OPC_OP_IMM = 7'b0010011,  // I-type ALU and shifts
        OPC_BRANCH = 7'b1100011   // Conditional branches
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Only BEQ and BNE are resolved, everything else is not a branch
    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } branch_op_e;

endpackage

/* tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int INIT_LEN       = 15;   // ADDI seeds for x1..x15
    localparam int BODY_LEN       = 80;
    localparam int TAIL_LEN       = 8;
    localparam int PROG_LEN       = INIT_LEN + BODY_LEN + TAIL_LEN;
    localparam int STROBE_TIMEOUT = 200;
    localparam int DRAIN_CYCLES   = PROG_LEN + 20;
    localparam logic [31:0] NOP   = 32'h0000_0013;  // addi x0, x0, 0

    logic                clk;
    logic                reset_n;
    logic [`RV_XLEN-1:0] instr_addr;
    logic [31:0]         instr_data;
    logic                result_valid;
    logic [`RV_XLEN-1:0] result_data;

    logic [31:0] imem [0:PROG_LEN-1];
    logic [31:0] expected_q [$];   // x10 values in program order
    logic [31:0] fetch_q [$];      // Fetch addresses in cycle order
    integer      seed;

    rv_core uut (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    // Same-cycle instruction memory with NOPs past the end
    assign instr_data = (instr_addr[31:2] < PROG_LEN) ? imem[instr_addr[31:2]] : NOP;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Instruction encoding and program generation
    // ------------------------------------------------------------------------
    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic build_program();
        int          i;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [12:0] off;
        for (i = 0; i < INIT_LEN; i++) begin
            imem[i] = i_type_word(12'($random(seed)), 5'd0, 3'b000, 5'(i + 1));
        end
        for (i = INIT_LEN; i < INIT_LEN + BODY_LEN; i++) begin
            kind = rand_below(10);
            rd   = (rand_below(2) == 0) ? `RV_RESULT_REG : 5'(rand_below(16));
            rs1  = (rand_below(4) == 0) ? `RV_RESULT_REG : 5'(rand_below(16));
            rs2  = (rand_below(4) == 0) ? `RV_RESULT_REG : 5'(rand_below(16));
            f3   = 3'(rand_below(8));
            alt  = (f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1;  // SUB, SRA, SRAI
            if (kind < 4) begin
                imem[i] = r_type_word(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
            end else if (kind < 8) begin
                imm = 12'($random(seed));
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {((f3 == 3'd5 && alt) ? 7'b0100000 : 7'b0000000), imm[4:0]};
                end
                imem[i] = i_type_word(imm, rs1, f3, rd);
            end else begin
                off = 13'(4 * (2 + rand_below(3)));  // Skips one to three
                if (rand_below(3) == 0) begin
                    rs2 = rs1;  // Equal operands
                end
                imem[i] = branch_word(off, rs2, rs1, 3'(rand_below(2)));
            end
        end
        for (i = INIT_LEN + BODY_LEN; i < PROG_LEN; i++) begin
            imem[i] = NOP;
        end
    endtask

    // ------------------------------------------------------------------------
    // Sequential ISA model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] isa_alu(input logic [31:0] instr, input logic [31:0] a,
                                            input logic [31:0] rb);
        logic        is_imm;
        logic [31:0] b;
        logic [4:0]  sh;
        is_imm = (instr[6:0] == OPC_OP_IMM);
        b      = is_imm ? {{20{instr[31]}}, instr[31:20]} : rb;
        sh     = b[4:0];
        case (instr[14:12])
            3'd0:    return (instr[30] && !is_imm) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};  // Unsigned compare also for SLTIU
            3'd4:    return a ^ b;
            3'd5:    return instr[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void run_reference();
        logic [31:0] regs [0:31];
        logic [31:0] instr;
        logic [31:0] value;
        logic [31:0] b_off;
        logic        taken;
        int          idx;
        for (idx = 0; idx < 32; idx++) begin
            regs[idx] = '0;
        end
        idx = 0;
        while (idx < PROG_LEN) begin
            instr = imem[idx];
            fetch_q.push_back(`RV_RESET_PC + 32'(4 * idx));
            if (instr[6:0] == OPC_BRANCH) begin
                taken = (regs[instr[19:15]] == regs[instr[24:20]]) ^ instr[12];  // BNE inverts
                b_off = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                if (taken) begin
                    // Two wrong-path words are fetched before the target
                    fetch_q.push_back(`RV_RESET_PC + 32'(4 * (idx + 1)));
                    fetch_q.push_back(`RV_RESET_PC + 32'(4 * (idx + 2)));
                end
                idx   = taken ? idx + int'(b_off >> 2) : idx + 1;
            end else begin
                value = isa_alu(instr, regs[instr[19:15]], regs[instr[24:20]]);
                if (instr[11:7] != 5'd0) begin
                    regs[instr[11:7]] = value;
                end
                if (instr[11:7] == `RV_RESULT_REG) begin
                    expected_q.push_back(value);
                end
                idx++;
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus and checking
    // ------------------------------------------------------------------------
    initial begin : stimulus
        seed    = 96;
        reset_n = 1'b0;
        build_program();
        run_reference();
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "test stopped");
    endtask

    // Outputs only move on the rising edge
    task automatic wait_result(input int limit, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            seen = (result_valid === 1'b1);
            cycles++;
        end
    endtask

    // Entry 0 is the reset PC, fetched in the cycle that releases reset
    initial begin : fetch_check
        int cycles;
        int k;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            abort_run("Reset was never released");
        end
        for (k = 1; k < fetch_q.size(); k++) begin
            @(negedge clk);
            check_fetch: assert (instr_addr === fetch_q[k]) else begin
                $display("** Error @ %0t: fetch %0d expected address %h, got %h",
                         $time, k, fetch_q[k], instr_addr);
                abort_run("Fetch address mismatch");
            end
        end
    end

    initial begin : compare
        logic seen;
        int   n;
        int   cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            abort_run("Reset was never released");
        end
        if (expected_q.size() == 0) begin
            abort_run("Generated program never writes the result register");
        end
        for (n = 0; n < expected_q.size(); n++) begin
            wait_result(STROBE_TIMEOUT, seen);
            if (!seen) begin
                abort_run($sformatf("No result strobe for value %0d of %0d within %0d cycles",
                                    n, expected_q.size(), STROBE_TIMEOUT));
            end
            check_value: assert (result_data === expected_q[n]) else begin
                $display("** Error @ %0t: result %0d expected %h, got %h",
                         $time, n, expected_q[n], result_data);
                abort_run("Result value mismatch");
            end
        end
        wait_result(DRAIN_CYCLES, seen);  // Squashed writes must not show up late
        if (seen) begin
            abort_run($sformatf("Extra result strobe after %0d values, data %h",
                                expected_q.size(), result_data));
        end else begin
            $display("%0d results checked", expected_q.size());
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* writeback_regfile.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module writeback_regfile (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [4:0]          ex_rd,
    input  logic                ex_reg_write,
    input  logic [`RV_XLEN-1:0] ex_result,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    output logic [4:0]          wb_rd,
    output logic                wb_reg_write,
    output logic [`RV_XLEN-1:0] wb_data,
    output logic                result_valid,
    output logic [`RV_XLEN-1:0] result_data
);

    logic [`RV_XLEN-1:0] regs [1:31];  // x0 is not stored

    // ------------------------------------------------------------------------
    // MEM/WB register, MEM stage carries no memory access
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

    always_ff @(posedge clk) begin
        if (wb_reg_write && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle write is visible to decode
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wb_reg_write && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // Result strobe one cycle after the x10 write
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= wb_reg_write && wb_rd == `RV_RESULT_REG;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_reg_write && wb_rd == `RV_RESULT_REG) begin
            result_data <= wb_data;
        end
    end

    x0_reads_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (rs1_addr != 5'd0 || rs1_data == '0) && (rs2_addr != 5'd0 || rs2_data == '0))
        else $error("writeback_regfile: x0 read nonzero");

endmodule
